// ==== src/bus_map_pkg.sv ====
/* address map of the system bus: bus widths, region enum, memory sizes,
   region base bytes and custom register offsets */

package bus_map_pkg;

	// bus widths, addr is the 68000 word address A23..A1
	localparam int unsigned ADDR_W = 23;
	localparam int unsigned DATA_W = 16;
	localparam int unsigned BE_W   = 2;

	// decoded target of one processor access
	typedef enum logic [2:0] {
		reg_none,   // unmapped, reads as zero
		reg_chip,
		reg_kick,
		reg_cia,
		reg_custom,
		reg_rtc
	} region_t;

	// memory sizes in words, both mirror through their whole range
	localparam int unsigned CHIP_WORDS = 1024;
	localparam int unsigned KICK_WORDS = 16;
	localparam int unsigned CHIP_AW    = $clog2(CHIP_WORDS);
	localparam int unsigned KICK_AW    = $clog2(KICK_WORDS);
	localparam string       KICK_FILE  = "src/kick_rom.hex";

	// range tags on the upper word address bits
	localparam logic [2:0]  CHIP_HI     = 3'b000;   // A23..A21, 0x000000-0x1fffff
	localparam logic [4:0]  KICK_HI     = 5'h1f;    // A23..A19, 0xf80000-0xffffff
	localparam logic [7:0]  CIA_BASE    = 8'hbf;    // top address byte
	localparam int unsigned CIA_A_SEL   = 11;       // word bit of A12, low selects CIA-A
	localparam logic [7:0]  RTC_BASE    = 8'hdc;
	localparam logic [11:0] CUSTOM_BASE = 12'hdff;  // custom page, A23..A12

	// custom register byte offsets inside the page
	localparam logic [11:0] INTENAR = 12'h01c;
	localparam logic [11:0] INTREQR = 12'h01e;
	localparam logic [11:0] INTENA  = 12'h09a;
	localparam logic [11:0] INTREQ  = 12'h09c;

endpackage

// ==== src/sys_ctrl_pkg.sv ====
/* system control definitions: reset hold, bridge wait counts and states,
   interrupt register layout and level table */

package sys_ctrl_pkg;

	// reset stretch
	localparam int unsigned RESET_HOLD = 64;
	localparam int unsigned HOLD_W     = $clog2(RESET_HOLD);

	// extra cycles in st_wait, counted down to zero
	localparam int unsigned     WAIT_W    = 4;
	localparam logic [WAIT_W-1:0] FAST_WAIT = 4'd1;
	localparam logic [WAIT_W-1:0] CIA_WAIT  = 4'd9;   // slow E-clock style access

	typedef enum logic [1:0] {st_idle, st_wait, st_done} bridge_state_t;

	// intena/intreq layout
	localparam int unsigned IRQ_W      = 14;
	localparam int unsigned INT_MASTER = 14;   // master enable in intena
	localparam int unsigned INT_SETCLR = 15;   // 1 sets, 0 clears the written ones

	// priority level of each request bit, index 0 first
	localparam logic [2:0] LEVEL_OF_BIT [IRQ_W] = '{
		3'd1, 3'd1, 3'd1, 3'd2, 3'd3, 3'd3, 3'd3,
		3'd4, 3'd4, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6
	};

endpackage

// ==== src/cpu_bus_if.sv ====
/* internal processor bus: one accepted request plus its decoded region */

`timescale 1ns/1ns

interface cpu_bus_if import bus_map_pkg::*; ();

	logic [ADDR_W-1:0] addr;    // word address
	logic [DATA_W-1:0] wdata;
	logic              we;
	logic [BE_W-1:0]   be;      // [1] upper byte, [0] lower byte
	logic              strobe;  // one cycle, the accept cycle
	region_t           region;

	// request side, needs the region for its wait count
	modport bridge (
		output addr, wdata, we, be, strobe,
		input  region
	);

	// strobe and we feed the overlay register
	modport decoder (
		input  addr, we, strobe,
		output region
	);

	modport slave (
		input addr, wdata, we, be, strobe, region
	);

endinterface

// ==== src/reset_control.sv ====
/* reset sequencing: system reset hold counter and two-stage release of
   the processor reset */

`timescale 1ns/1ns

module reset_control
	import sys_ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic kbd_rst,     // keyboard reset request
	output logic sys_reset,
	output logic cpu_reset
);

	logic [HOLD_W-1:0] hold_cnt;
	logic              rst_sync;   // first release stage

	// hold counter, any source restarts it
	always_ff @(posedge clk) begin
		if (reset || kbd_rst) begin
			hold_cnt  <= '0;
			sys_reset <= 1'b1;
		end else if (sys_reset) begin
			if (hold_cnt == HOLD_W'(RESET_HOLD - 1))
				sys_reset <= 1'b0;   // RESET_HOLD cycles after the source fell
			else
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// processor leaves reset two cycles after the system
	always_ff @(posedge clk) begin
		if (reset) begin
			rst_sync  <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			rst_sync  <= sys_reset;
			cpu_reset <= rst_sync;
		end
	end

endmodule

// ==== src/bus_bridge.sv ====
/* processor bus bridge: valid/ready port, wait-state FSM and the
   wired-OR read data bus */

`timescale 1ns/1ns

module bus_bridge
	import bus_map_pkg::*;
	import sys_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              sys_reset,
	// processor port
	input  logic              cpu_valid,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic              cpu_we,
	input  logic [BE_W-1:0]   cpu_be,
	input  logic [DATA_W-1:0] cpu_wdata,
	output logic              cpu_ready,
	output logic [DATA_W-1:0] cpu_rdata,
	// internal bus and slave read ports
	cpu_bus_if.bridge         bus,
	input  logic [DATA_W-1:0] chip_rdata,
	input  logic [DATA_W-1:0] custom_rdata
);

	bridge_state_t     state;
	logic [WAIT_W-1:0] wait_cnt;   // remaining extra cycles
	logic              accept;

	//--------------------------------------------------------------------------
	// request path

	// master holds the fields until ready, so they go straight onto the bus
	assign bus.addr  = cpu_addr;
	assign bus.wdata = cpu_wdata;
	assign bus.we    = cpu_we;
	assign bus.be    = cpu_be;

	assign accept     = cpu_valid && (state == st_idle) && !sys_reset;
	assign bus.strobe = accept;   // slaves sample on the accept edge

	//--------------------------------------------------------------------------
	// cycle sequencing

	always_ff @(posedge clk) begin
		if (sys_reset) begin
			state    <= st_idle;
			wait_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_wait;
						// cia region is the slow one
						wait_cnt <= (bus.region == reg_cia) ? CIA_WAIT : FAST_WAIT;
					end
				end
				st_wait: begin
					if (wait_cnt == '0)
						state <= st_done;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				st_done: state <= st_idle;   // single ready cycle
				default: state <= st_idle;
			endcase
		end
	end

	assign cpu_ready = (state == st_done);

	// wired-OR, each slave returns zero outside its own region
	assign cpu_rdata = chip_rdata | custom_rdata;

endmodule

// ==== src/address_decoder.sv ====
/* address decoder: word address to region, kickstart overlay register */

`timescale 1ns/1ns

module address_decoder
	import bus_map_pkg::*;
(
	input  logic       clk,
	input  logic       cpu_reset,
	cpu_bus_if.decoder bus
);

	logic    ovl;          // rom mapped over chip space
	logic    in_chip;
	logic    in_kick;
	logic    in_cia;
	logic    in_rtc;
	logic    in_custom;
	logic    cia_a_wr;
	region_t region_d;

	//--------------------------------------------------------------------------
	// range compares on the upper address bits

	assign in_chip   = (bus.addr[ADDR_W-1 -: 3] == CHIP_HI);
	assign in_kick   = (bus.addr[ADDR_W-1 -: 5] == KICK_HI);
	assign in_cia    = (bus.addr[ADDR_W-1 -: 8] == CIA_BASE);
	assign in_rtc    = (bus.addr[ADDR_W-1 -: 8] == RTC_BASE);
	assign in_custom = (bus.addr[ADDR_W-1 -: 12] == CUSTOM_BASE);

	always_comb begin
		region_d = reg_none;   // unmapped default
		if (in_chip)
			region_d = (ovl && !bus.we) ? reg_kick : reg_chip;   // writes still hit ram
		else if (in_kick)
			region_d = reg_kick;
		else if (in_cia)
			region_d = reg_cia;
		else if (in_rtc)
			region_d = reg_rtc;
		else if (in_custom)
			region_d = reg_custom;
	end

	assign bus.region = region_d;

	//--------------------------------------------------------------------------
	// overlay, set through processor reset, cleared by first CIA-A write

	assign cia_a_wr = bus.strobe && bus.we && (region_d == reg_cia) &&
		!bus.addr[CIA_A_SEL];

	always_ff @(posedge clk) begin
		if (cpu_reset)
			ovl <= 1'b1;
		else if (cia_a_wr)
			ovl <= 1'b0;
	end

endmodule

// ==== src/mem_banks.sv ====
/* memory banks: chip ram with byte writes and the kickstart rom */

`timescale 1ns/1ns

module mem_banks
	import bus_map_pkg::*;
(
	input  logic              clk,
	cpu_bus_if.slave          bus,
	output logic [DATA_W-1:0] chip_rdata
);

	logic [DATA_W-1:0]  chip_ram [CHIP_WORDS];
	logic [DATA_W-1:0]  kick_rom [KICK_WORDS];
	logic [CHIP_AW-1:0] chip_idx;   // low bits only, ram mirrors
	logic [KICK_AW-1:0] kick_idx;
	logic               chip_wr;
	logic               chip_rd;
	logic               kick_rd;

	initial $readmemh(KICK_FILE, kick_rom);

	assign chip_idx = bus.addr[CHIP_AW-1:0];
	assign kick_idx = bus.addr[KICK_AW-1:0];
	assign chip_wr  = bus.strobe && bus.we && (bus.region == reg_chip);
	assign chip_rd  = !bus.we && (bus.region == reg_chip);
	assign kick_rd  = !bus.we && (bus.region == reg_kick);   // rom writes dropped

	always_ff @(posedge clk) begin
		if (chip_wr) begin
			for (int b = 0; b < BE_W; b++) begin
				if (bus.be[b])
					chip_ram[chip_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
		// read word held until the next strobe
		if (bus.strobe) begin
			if (chip_rd)
				chip_rdata <= chip_ram[chip_idx];
			else if (kick_rd)
				chip_rdata <= kick_rom[kick_idx];
			else
				chip_rdata <= '0;
		end
	end

endmodule

// ==== src/custom_regs.sv ====
/* custom register logic: intena/intreq with set/clear writes, interrupt
   priority encoder with level 7 override, rtc nibble window */

`timescale 1ns/1ns

module custom_regs
	import bus_map_pkg::*;
	import sys_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              sys_reset,
	cpu_bus_if.slave          bus,
	input  logic [IRQ_W-1:0]  irq_in,
	input  logic              int7,         // forces level 7
	input  logic [63:0]       rtc,          // 16 bcd nibbles
	output logic [DATA_W-1:0] custom_rdata,
	output logic [2:0]        cpu_ipl       // active high level
);

	logic [IRQ_W:0]   intena;       // bit 14 master enable
	logic [IRQ_W-1:0] intreq;
	logic [IRQ_W:0]   intena_nxt;
	logic [IRQ_W-1:0] intreq_nxt;
	logic [2:0]       level_nxt;
	logic [11:0]      reg_off;      // byte offset in custom page
	logic             reg_wr;
	logic             reg_rd;
	logic             rtc_rd;
	logic [3:0]       rtc_nib;

	assign reg_off = {bus.addr[10:0], 1'b0};
	assign reg_wr  = bus.strobe && bus.we && (bus.region == reg_custom);
	assign reg_rd  = !bus.we && (bus.region == reg_custom);
	assign rtc_rd  = !bus.we && (bus.region == reg_rtc);
	assign rtc_nib = rtc[{bus.addr[4:1], 2'b00} +: 4];   // A5..A2 pick the nibble

	//--------------------------------------------------------------------------
	// next register state and priority level

	always_comb begin
		intena_nxt = intena;
		intreq_nxt = intreq;
		if (reg_wr && (reg_off == INTENA)) begin
			if (bus.wdata[INT_SETCLR])
				intena_nxt = intena | bus.wdata[IRQ_W:0];
			else
				intena_nxt = intena & ~bus.wdata[IRQ_W:0];
		end
		if (reg_wr && (reg_off == INTREQ)) begin
			if (bus.wdata[INT_SETCLR])
				intreq_nxt = intreq | bus.wdata[IRQ_W-1:0];
			else
				intreq_nxt = intreq & ~bus.wdata[IRQ_W-1:0];
		end
		intreq_nxt = intreq_nxt | irq_in;   // hardware requests win over a clear

		level_nxt = 3'd0;
		if (intena_nxt[INT_MASTER]) begin
			for (int i = 0; i < IRQ_W; i++) begin
				if (intena_nxt[i] && intreq_nxt[i] && (LEVEL_OF_BIT[i] > level_nxt))
					level_nxt = LEVEL_OF_BIT[i];
			end
		end
		if (int7)
			level_nxt = 3'd7;
	end

	//--------------------------------------------------------------------------
	// registers

	always_ff @(posedge clk) begin
		if (sys_reset) begin
			intena  <= '0;
			intreq  <= '0;
			cpu_ipl <= 3'd0;
		end else begin
			intena  <= intena_nxt;
			intreq  <= intreq_nxt;
			cpu_ipl <= level_nxt;   // same edge as the registers
		end
	end

	// read data, zero unless the last strobe hit custom or rtc
	always_ff @(posedge clk) begin
		if (bus.strobe) begin
			if (reg_rd && (reg_off == INTENAR))
				custom_rdata <= DATA_W'(intena);
			else if (reg_rd && (reg_off == INTREQR))
				custom_rdata <= DATA_W'(intreq);
			else if (rtc_rd)
				custom_rdata <= DATA_W'(rtc_nib);
			else
				custom_rdata <= '0;
		end
	end

endmodule

// ==== src/minimig_core.sv ====
/* system bus core top level: reset control, bus bridge, address decoder,
   memory banks and custom registers on one internal bus */

`timescale 1ns/1ns

module minimig_core
	import bus_map_pkg::*;
	import sys_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              kbd_rst,
	// processor port
	input  logic              cpu_valid,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic              cpu_we,
	input  logic [BE_W-1:0]   cpu_be,
	input  logic [DATA_W-1:0] cpu_wdata,
	output logic              cpu_ready,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic [2:0]        cpu_ipl,
	output logic              cpu_reset,
	// interrupt and rtc sources
	input  logic [IRQ_W-1:0]  irq_in,
	input  logic              int7,
	input  logic [63:0]       rtc,
	output logic              rst_out    // system reset status
);

	logic              sys_reset;
	logic [DATA_W-1:0] chip_rdata;
	logic [DATA_W-1:0] custom_rdata;

	cpu_bus_if bus ();

	//--------------------------------------------------------------------------
	// instances

	reset_control reset_control_i (
		.clk       (clk),
		.reset     (reset),
		.kbd_rst   (kbd_rst),
		.sys_reset (sys_reset),
		.cpu_reset (cpu_reset)
	);

	bus_bridge bus_bridge_i (
		.clk          (clk),
		.sys_reset    (sys_reset),
		.cpu_valid    (cpu_valid),
		.cpu_addr     (cpu_addr),
		.cpu_we       (cpu_we),
		.cpu_be       (cpu_be),
		.cpu_wdata    (cpu_wdata),
		.cpu_ready    (cpu_ready),
		.cpu_rdata    (cpu_rdata),
		.bus          (bus.bridge),
		.chip_rdata   (chip_rdata),
		.custom_rdata (custom_rdata)
	);

	address_decoder address_decoder_i (
		.clk       (clk),
		.cpu_reset (cpu_reset),   // overlay set while the processor is held
		.bus       (bus.decoder)
	);

	mem_banks mem_banks_i (
		.clk        (clk),
		.bus        (bus.slave),
		.chip_rdata (chip_rdata)
	);

	custom_regs custom_regs_i (
		.clk          (clk),
		.sys_reset    (sys_reset),
		.bus          (bus.slave),
		.irq_in       (irq_in),
		.int7         (int7),
		.rtc          (rtc),
		.custom_rdata (custom_rdata),
		.cpu_ipl      (cpu_ipl)
	);

	assign rst_out = sys_reset;

endmodule

// ==== sim/tb_model.svh ====
/* reference model: chip ram, kickstart rom, overlay flag, interrupt
   registers and the interrupt level rule */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	logic [DATA_W-1:0] m_ram [CHIP_WORDS];
	logic [DATA_W-1:0] m_rom [KICK_WORDS];
	logic              m_ovl;        // rom over chip space
	logic [IRQ_W:0]    m_intena;     // bit 14 master enable
	logic [IRQ_W-1:0]  m_intreq;

	initial $readmemh("src/kick_rom.hex", m_rom);

	// level by request bit ranges
	function automatic logic [2:0] bit_level(input int i);
		if (i <= 2)
			return 3'd1;
		if (i == 3)
			return 3'd2;
		if (i <= 6)
			return 3'd3;
		if (i <= 10)
			return 3'd4;
		if (i <= 12)
			return 3'd5;
		return 3'd6;
	endfunction

	function automatic logic [2:0] expected_level();
		logic [2:0] lvl;
		lvl = 3'd0;
		if (m_intena[14]) begin   // master enable gates everything
			for (int i = 0; i < IRQ_W; i++) begin
				if (m_intena[i] && m_intreq[i] && bit_level(i) > lvl)
					lvl = bit_level(i);
			end
		end
		return lvl;
	endfunction

	task automatic clear_on_reset();
		m_ovl    = 1'b1;
		m_intena = '0;
		m_intreq = '0;
	endtask

	task automatic ram_store(input logic [ADDR_W-1:0] a, input logic [1:0] be,
		input logic [DATA_W-1:0] d);
		if (be[0])
			m_ram[a[9:0]][7:0] = d[7:0];   // ram mirrors on the low 10 bits
		if (be[1])
			m_ram[a[9:0]][15:8] = d[15:8];
	endtask

	// chip range read, rom while the overlay is on
	function automatic logic [DATA_W-1:0] chip_value(input logic [ADDR_W-1:0] a);
		if (m_ovl)
			return m_rom[a[3:0]];
		return m_ram[a[9:0]];
	endfunction

	task automatic cia_write_seen(input logic [ADDR_W-1:0] a);
		if (!a[11])
			m_ovl = 1'b0;   // cia-a, A12 low
	endtask

	task automatic intena_write(input logic [DATA_W-1:0] d);
		if (d[15])
			m_intena = m_intena | d[14:0];
		else
			m_intena = m_intena & ~d[14:0];
	endtask

	task automatic intreq_write(input logic [DATA_W-1:0] d);
		if (d[15])
			m_intreq = m_intreq | d[13:0];
		else
			m_intreq = m_intreq & ~d[13:0];
	endtask

	// byte address bits 5:2 pick the nibble
	function automatic logic [DATA_W-1:0] rtc_nibble(input logic [63:0] v,
		input logic [ADDR_W-1:0] a);
		return DATA_W'((v >> (4 * a[4:1])) & 64'hf);
	endfunction

`endif

// ==== sim/tb_minimig.sv ====
/* testbench for the system bus core: clock, reset, random accesses
   against the model, timeout and result report */

`timescale 1ns/1ns

module tb_minimig
	import bus_map_pkg::*;
	import sys_ctrl_pkg::*;
();

	localparam int N_OVL    = 8;
	localparam int N_RAM    = 200;
	localparam int N_NONE   = 16;
	localparam int N_IRQ    = 120;
	localparam int N_RTC    = 32;
	localparam int RST_CYC  = 16;
	localparam int FAST_LAT = 2;    // accept to ready
	localparam int CIA_LAT  = 10;
	localparam int ACC_MAX  = CIA_LAT + 2;   // plus drive and idle return
	localparam int STEPS    = 3 * N_OVL + 6 + CHIP_WORDS + N_RAM + N_NONE + 4 +
		2 * N_IRQ + N_RTC;
	localparam int LIMIT    = 2 * (STEPS * ACC_MAX + 2 * (RST_CYC + RESET_HOLD + 4));

	logic              clk;
	logic              reset;
	logic              kbd_rst;
	logic              cpu_valid;
	logic [ADDR_W-1:0] cpu_addr;
	logic              cpu_we;
	logic [BE_W-1:0]   cpu_be;
	logic [DATA_W-1:0] cpu_wdata;
	logic              cpu_ready;
	logic [DATA_W-1:0] cpu_rdata;
	logic [2:0]        cpu_ipl;
	logic              cpu_reset;
	logic [IRQ_W-1:0]  irq_in;
	logic              int7;
	logic [63:0]       rtc;
	logic              rst_out;

	int errors;
	int test_errors;   // error count at test start
	int checks;
	int tests;
	int cycles;

	`include "tb_model.svh"

	minimig_core dut_i (
		.clk       (clk),
		.reset     (reset),
		.kbd_rst   (kbd_rst),
		.cpu_valid (cpu_valid),
		.cpu_addr  (cpu_addr),
		.cpu_we    (cpu_we),
		.cpu_be    (cpu_be),
		.cpu_wdata (cpu_wdata),
		.cpu_ready (cpu_ready),
		.cpu_rdata (cpu_rdata),
		.cpu_ipl   (cpu_ipl),
		.cpu_reset (cpu_reset),
		.irq_in    (irq_in),
		.int7      (int7),
		.rtc       (rtc),
		.rst_out   (rst_out)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// run limit
	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", LIMIT);
		$display("Done: errors found");
		$finish;
	end

	// ------------------------------------------------------------------------
	// helpers

	task automatic next_cycle();
		@(posedge clk);
		#1;   // sample and drive just after the edge
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("FAIL %0t %s", $time, what);
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %s: %s, %0d errors", name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		test_errors = errors;
	endtask

	// one request, waits for ready, returns data and accept-to-ready cycles
	task automatic bus_access(input logic [ADDR_W-1:0] a, input logic we,
		input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wd,
		output logic [DATA_W-1:0] rd, output int lat);
		int n;
		n         = 0;
		lat       = -1;
		rd        = '0;
		cpu_valid = 1'b1;
		cpu_addr  = a;
		cpu_we    = we;
		cpu_be    = be;
		cpu_wdata = wd;
		while (lat < 0 && n < ACC_MAX + 8) begin
			next_cycle();
			n++;
			if (cpu_ready) begin
				lat = n - 1;   // first edge accepts
				rd  = cpu_rdata;
			end
		end
		cpu_valid = 1'b0;
		if (lat < 0)
			report_failure("cpu_ready never came for a request");
		next_cycle();   // bridge back in idle
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] be,
		input logic [DATA_W-1:0] d, input int exp_lat);
		logic [DATA_W-1:0] rd;
		int                lat;
		bus_access(a, 1'b1, be, d, rd, lat);
		compare_value("ready latency", lat, exp_lat);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] exp,
		input int exp_lat);
		logic [DATA_W-1:0] rd;
		int                lat;
		bus_access(a, 1'b0, '1, '0, rd, lat);
		compare_value("ready latency", lat, exp_lat);
		compare_value("cpu_rdata", rd, exp);
	endtask

	// random mirror inside chip space
	function automatic logic [ADDR_W-1:0] chip_addr(input int unsigned idx);
		logic [ADDR_W-1:0] a;
		a = ADDR_W'($urandom) & 23'h0fffff;
		a[CHIP_AW-1:0] = idx[CHIP_AW-1:0];
		return a;
	endfunction

	function automatic logic [ADDR_W-1:0] none_addr();
		logic [2:0] top;
		top = 3'(1 + $urandom % 4);   // 0x200000-0x9fffff, unmapped
		return {top, 20'($urandom)};
	endfunction

	function automatic logic [ADDR_W-1:0] cia_addr(input logic sel_a);
		logic [ADDR_W-1:0] a;
		a            = {CIA_BASE, 15'($urandom)};
		a[CIA_A_SEL] = !sel_a;
		return a;
	endfunction

	function automatic logic [ADDR_W-1:0] rtc_addr(input logic [3:0] nib);
		logic [ADDR_W-1:0] a;
		a      = {RTC_BASE, 15'($urandom)};
		a[4:1] = nib;
		return a;
	endfunction

	function automatic logic [ADDR_W-1:0] custom_addr(input logic [11:0] off);
		return {CUSTOM_BASE, off[11:1]};
	endfunction

	// ------------------------------------------------------------------------
	// tests

	task automatic count_release();
		int n;
		int m;
		n = 0;
		while (rst_out && n < RESET_HOLD + 8) begin
			next_cycle();
			n++;
		end
		compare_value("rst_out hold", n, RESET_HOLD);
		m = 0;
		while (cpu_reset && m < 8) begin
			next_cycle();
			m++;
		end
		compare_value("cpu_reset delay", m, 2);
	endtask

	task automatic reset_sequencing();
		compare_value("cpu_reset", cpu_reset, 1);
		compare_value("rst_out", rst_out, 1);
		compare_value("cpu_ready", cpu_ready, 0);
		compare_value("cpu_ipl", cpu_ipl, 0);
		reset = 1'b0;
		count_release();
		kbd_rst = 1'b1;   // one cycle keyboard request
		next_cycle();
		compare_value("rst_out", rst_out, 1);
		kbd_rst = 1'b0;
		count_release();
		clear_on_reset();
		report_test("reset");
	endtask

	task automatic overlay_switch();
		logic [ADDR_W-1:0] addrs [N_OVL];
		logic [DATA_W-1:0] d;
		for (int i = 0; i < N_OVL; i++) begin
			addrs[i] = chip_addr($urandom % CHIP_WORDS);
			d        = DATA_W'($urandom);
			write_word(addrs[i], 2'b11, d, FAST_LAT);   // lands in ram
			ram_store(addrs[i], 2'b11, d);
		end
		for (int i = 0; i < N_OVL; i++)
			read_word(addrs[i], chip_value(addrs[i]), FAST_LAT);
		write_word(cia_addr(1'b0), 2'b11, DATA_W'($urandom), CIA_LAT);   // cia-b only
		read_word(addrs[0], chip_value(addrs[0]), FAST_LAT);
		d = DATA_W'($urandom);
		addrs[0] = cia_addr(1'b1);
		write_word(addrs[0], 2'b11, d, CIA_LAT);
		cia_write_seen(addrs[0]);
		read_word(cia_addr(1'b1), '0, CIA_LAT);   // no cia chips left
		addrs[0] = chip_addr($urandom % CHIP_WORDS);
		write_word(addrs[0], 2'b11, 16'h0f0f, FAST_LAT);
		ram_store(addrs[0], 2'b11, 16'h0f0f);
		for (int i = 0; i < N_OVL; i++)
			read_word(addrs[i], chip_value(addrs[i]), FAST_LAT);
		report_test("overlay");
	endtask

	task automatic chip_ram_access();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		logic [BE_W-1:0]   be;
		// full fill first, partial writes then meet known data
		for (int i = 0; i < CHIP_WORDS; i++) begin
			a = chip_addr(i);
			d = DATA_W'(i * 40503) ^ 16'h5a5a;   // odd multiplier, every bit counts
			write_word(a, 2'b11, d, FAST_LAT);
			ram_store(a, 2'b11, d);
		end
		for (int i = 0; i < N_RAM; i++) begin
			a = chip_addr($urandom % CHIP_WORDS);
			if ($urandom % 2) begin
				d  = DATA_W'($urandom);
				be = BE_W'($urandom);
				write_word(a, be, d, FAST_LAT);
				ram_store(a, be, d);
			end else begin
				read_word(a, chip_value(a), FAST_LAT);
			end
		end
		for (int i = 0; i < N_NONE; i++)
			read_word(none_addr(), '0, FAST_LAT);
		for (int i = 0; i < 4; i++) begin
			a = {5'h1f, 18'($urandom)};   // rom at the top of the map
			read_word(a, m_rom[a[3:0]], FAST_LAT);
		end
		report_test("chip_ram");
	endtask

	task automatic interrupt_levels();
		logic [IRQ_W-1:0]  bits;
		logic [DATA_W-1:0] d;
		for (int i = 0; i < N_IRQ; i++) begin
			case ($urandom % 5)
				0: begin
					bits   = IRQ_W'($urandom) & IRQ_W'($urandom);   // sparse
					irq_in = bits;
					next_cycle();
					irq_in   = '0;
					m_intreq = m_intreq | bits;
				end
				1: begin
					d = DATA_W'($urandom);
					write_word(custom_addr(INTENA), 2'b11, d, FAST_LAT);
					intena_write(d);
				end
				2: begin
					d = DATA_W'($urandom);
					write_word(custom_addr(INTREQ), 2'b11, d, FAST_LAT);
					intreq_write(d);
				end
				3: begin
					read_word(custom_addr(INTENAR), DATA_W'(m_intena), FAST_LAT);
					read_word(custom_addr(INTREQR), DATA_W'(m_intreq), FAST_LAT);
				end
				default: begin
					int7 = 1'b1;
					next_cycle();
					compare_value("cpu_ipl", cpu_ipl, 3'd7);
					int7 = 1'b0;
					next_cycle();
				end
			endcase
			compare_value("cpu_ipl", cpu_ipl, expected_level());
		end
		report_test("interrupts");
	endtask

	task automatic rtc_window();
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < N_RTC; i++) begin
			rtc = {$urandom, $urandom};
			a   = rtc_addr(4'($urandom));
			read_word(a, rtc_nibble(rtc, a), FAST_LAT);
		end
		report_test("rtc");
	endtask

	// ------------------------------------------------------------------------
	// main sequence

	initial begin
		void'($urandom(98089));
		errors      = 0;
		test_errors = 0;
		checks      = 0;
		tests       = 0;
		reset       = 1'b1;
		kbd_rst     = 1'b0;
		cpu_valid   = 1'b0;
		cpu_addr    = '0;
		cpu_we      = 1'b0;
		cpu_be      = '0;
		cpu_wdata   = '0;
		irq_in      = '0;
		int7        = 1'b0;
		rtc         = '0;
		clear_on_reset();
		repeat (RST_CYC) next_cycle();
		reset_sequencing();
		overlay_switch();
		chip_ram_access();
		interrupt_levels();
		rtc_window();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src/kick_rom.hex ====
// kickstart rom, one 16-bit hex word per line, word 0 first
1111
4ef9
00f8
00d2
0000
ffff
5a3c
c3a5
2468
9bdf
7e01
0180
a55a
3c5a
6d2e
8421

// ==== tb.f ====
+incdir+sim
src/bus_map_pkg.sv
src/sys_ctrl_pkg.sv
src/cpu_bus_if.sv
src/reset_control.sv
src/bus_bridge.sv
src/address_decoder.sv
src/mem_banks.sv
src/custom_regs.sv
src/minimig_core.sv
sim/tb_minimig.sv

// ==== Makefile ====
# Verilator build and run of the system bus core testbench

VERILATOR ?= verilator
TOP       ?= tb_minimig
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard src/*.sv src/*.hex sim/*.sv sim/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
